/* verilog.f */
cpu_pkg.sv
register_bank.sv
data_ram.sv
fetch.sv
decode.sv
execute.sv
memory_stage.sv
cpu.sv
tb_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the CPU testbench with Verilator, run it, and scan the log
set -eo pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_cpu -f verilog.f
./obj_dir/Vtb_cpu | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
    echo "Testbench reported a failure, see $LOG"
    exit 1
fi
echo "Run finished without failure, log in $LOG"

/* tb_cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int RAM_WORDS      = 64;
    localparam int RAM_AW         = $clog2(RAM_WORDS);
    localparam int N_PROGS        = 4;
    localparam int PROG_LEN       = 150;
    localparam int PROG_AW        = $clog2(PROG_LEN);
    localparam int DATA_WORDS     = 16; // Words touched by LW and SW
    localparam int DRAIN_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = N_PROGS * PROG_LEN * 4 + 200;

    logic                  clock;
    logic                  rst_n;
    logic                  enable;
    logic [XLEN-1:0]       imem_data;
    logic [XLEN-1:0]       imem_addr;
    logic                  retire_valid;
    logic [REG_ADDR_W-1:0] retire_rd;
    logic [XLEN-1:0]       retire_value;

    logic [XLEN-1:0]       prog [PROG_LEN];
    logic [REG_ADDR_W-1:0] exp_rd [$];
    logic [XLEN-1:0]       exp_value [$];
    int check_index    = 0;
    int retire_count   = 0;
    int enabled_cycles = 0;
    int value_errors   = 0;
    int order_errors   = 0;
    int count_errors   = 0;
    int low_left       = 0;
    int cycle_count    = 0;

    cpu #(
        .RAM_WORDS(RAM_WORDS)
    ) UUT (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .imem_data(imem_data), .imem_addr(imem_addr),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    // Instruction port answers in the same cycle
    assign imem_data = (imem_addr < 32'(PROG_LEN * 4)) ? prog[imem_addr[PROG_AW+1:2]] : NOP_INSTR;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs1, rs2);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3,
                                          input logic [4:0] rs1, rs2);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    // Small register pool so dependencies at distance 1 to 3 are common
    function automatic logic [4:0] rand_reg();
        return 5'($urandom_range(0, 7));
    endfunction

    task automatic gen_program();
        int i;
        int r;
        int pick;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, offset;
        i = 0;
        for (r = 1; r < 8; r++) begin
            prog[i] = enc_i(12'($urandom), 5'd0, 3'b000, 5'(r), OP_IMM);
            i++;
        end
        // RAM keeps old contents, so every data word is stored before any load
        for (r = 0; r < DATA_WORDS; r++) begin
            prog[i] = enc_s(12'(r * 4), 5'd0, 5'($urandom_range(1, 7)));
            i++;
        end
        while (i < PROG_LEN) begin
            pick   = $urandom_range(0, 15);
            rd     = rand_reg();
            rs1    = rand_reg();
            rs2    = rand_reg();
            imm    = 12'($urandom);
            offset = 12'($urandom_range(0, DATA_WORDS - 1) * 4);
            case (pick)
                0, 1, 2, 3, 4, 5: begin
                    case ($urandom_range(0, 5))
                        0:       prog[i] = enc_r(7'h00, 3'b000, rd, rs1, rs2); // ADD
                        1:       prog[i] = enc_r(7'h20, 3'b000, rd, rs1, rs2); // SUB
                        2:       prog[i] = enc_r(7'h00, 3'b111, rd, rs1, rs2); // AND
                        3:       prog[i] = enc_r(7'h00, 3'b110, rd, rs1, rs2); // OR
                        4:       prog[i] = enc_r(7'h00, 3'b100, rd, rs1, rs2); // XOR
                        default: prog[i] = enc_r(7'h00, 3'b010, rd, rs1, rs2); // SLT
                    endcase
                end
                6, 7, 8, 9: prog[i] = enc_i(imm, rs1, 3'b000, rd, OP_IMM);
                10, 11:     prog[i] = enc_i(offset, 5'd0, 3'b010, rd, OP_LOAD);
                12:         prog[i] = enc_s(offset, 5'd0, rs2);
                13, 14: begin
                    if ($urandom_range(0, 3) == 0) begin
                        rs2 = rs1; // Forces equal operands
                    end
                    prog[i] = enc_b(13'($urandom_range(2, 4) * 4), 3'($urandom_range(0, 1)),
                                    rs1, rs2);
                end
                default: prog[i] = enc_r(7'h00, 3'b001, rd, rs1, rs2); // SLL, outside the subset
            endcase
            i++;
        end
    endtask

    // ISA interpreter, fills the expected retire sequence
    task automatic run_model();
        logic [XLEN-1:0] model_regs [32];
        logic [XLEN-1:0] model_mem [RAM_WORDS];
        logic [XLEN-1:0] w, a, b, imm_i, imm_s, imm_b, result, addr, pc, pc_next;
        logic [6:0]      op, f7;
        logic [2:0]      f3;
        logic [4:0]      rd;
        logic            writes;
        exp_rd.delete();
        exp_value.delete();
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        foreach (model_mem[k]) begin
            model_mem[k] = '0;
        end
        pc = '0;
        while (pc < 32'(PROG_LEN * 4)) begin
            w       = prog[pc[PROG_AW+1:2]];
            op      = w[6:0];
            rd      = w[11:7];
            f3      = w[14:12];
            f7      = w[31:25];
            a       = model_regs[w[19:15]];
            b       = model_regs[w[24:20]];
            imm_i   = {{20{w[31]}}, w[31:20]};
            imm_s   = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            writes  = 1'b0;
            result  = '0;
            pc_next = pc + 4;
            if (op == OP_REG && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
                writes = 1'b1;
                case ({f7[5], f3})
                    4'b0_000: result = a + b;
                    4'b1_000: result = a - b;
                    4'b0_111: result = a & b;
                    4'b0_110: result = a | b;
                    4'b0_100: result = a ^ b;
                    4'b0_010: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:  writes = 1'b0;
                endcase
            end else if (op == OP_IMM && f3 == 3'b000) begin
                writes = 1'b1;
                result = a + imm_i;
            end else if (op == OP_LOAD && f3 == 3'b010) begin
                addr   = a + imm_i;
                writes = 1'b1;
                result = model_mem[addr[RAM_AW+1:2]];
            end else if (op == OP_STORE && f3 == 3'b010) begin
                addr = a + imm_s;
                model_mem[addr[RAM_AW+1:2]] = b;
            end else if (op == OP_BRANCH && (f3 == 3'b000 || f3 == 3'b001)) begin
                if ((a == b) != f3[0]) begin
                    pc_next = pc + imm_b;
                end
            end
            if (writes && rd != 5'd0) begin
                model_regs[rd] = result;
                exp_rd.push_back(rd);
                exp_value.push_back(result);
            end
            pc = pc_next;
        end
    endtask

    // One clock, then inputs 5 ns after the edge with random freezes
    task automatic step_cycle();
        @(posedge clock);
        #5;
        if (low_left > 0) begin
            enable   = 1'b0;
            low_left = low_left - 1;
        end else if ($urandom_range(0, 9) == 0) begin
            enable   = 1'b0;
            low_left = $urandom_range(0, 3); // Phase of one to four cycles
        end else begin
            enable = 1'b1;
        end
    endtask

    task automatic reset_and_load();
        step_cycle();
        rst_n = 1'b0;
        gen_program();
        run_model();
        repeat (4) step_cycle();
        rst_n = 1'b1;
    endtask

    task automatic print_error_counts();
        $display("Errors: %0d value, %0d sequence, %0d retire count",
                 value_errors, order_errors, count_errors);
    endtask

    // Retire checker, sampled mid-cycle where outputs are settled
    always @(negedge clock) begin
        if (!rst_n) begin
            check_index    = 0;
            retire_count   = 0;
            enabled_cycles = 0;
        end else begin
            if (retire_valid) begin
                if (enabled_cycles < 4) begin
                    order_errors++;
                    $display("Retire at %0t ns came before the first instruction could cross "
                             , $time, "the pipeline");
                end
                if (check_index >= exp_rd.size()) begin
                    order_errors++;
                    $display("Extra retire at %0t ns of x%0d = %h beyond the expected sequence",
                             $time, retire_rd, retire_value);
                end else begin
                    if (retire_rd !== exp_rd[check_index]) begin
                        value_errors++;
                        $display("CHECK FAILED at %0t ns: retire_rd got %0d expected %0d",
                                 $time, retire_rd, exp_rd[check_index]);
                    end
                    if (retire_value !== exp_value[check_index]) begin
                        value_errors++;
                        $display("CHECK FAILED at %0t ns: retire_value got %h expected %h",
                                 $time, retire_value, exp_value[check_index]);
                    end
                    check_index++;
                end
                retire_count++;
            end
            if (enable) begin
                enabled_cycles++;
            end
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d expected retires seen",
                 TIMEOUT_CYCLES, check_index, exp_rd.size());
        print_error_counts();
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int p;
        void'($urandom(99986));
        rst_n  = 1'b0;
        enable = 1'b1;
        foreach (prog[k]) begin
            prog[k] = NOP_INSTR;
        end
        for (p = 0; p < N_PROGS; p++) begin
            reset_and_load();
            // Fetch restarts from address zero
            if (imem_addr !== 32'h0000_0000) begin
                value_errors++;
                $display("CHECK FAILED at %0t ns: imem_addr got %h expected %h",
                         $time, imem_addr, 32'h0000_0000);
            end
            while (check_index < exp_rd.size()) begin
                step_cycle();
            end
            repeat (DRAIN_CYCLES) step_cycle(); // Catches late extra retires
            if (retire_count != exp_rd.size()) begin
                count_errors++;
                $display("Program %0d retired %0d instructions but the model expects %0d",
                         p, retire_count, exp_rd.size());
            end
        end
        print_error_counts();
        if (value_errors + order_errors + count_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cpu.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu #(
    parameter int RAM_WORDS = 64
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [cpu_pkg::XLEN-1:0]       imem_data,
    output logic [cpu_pkg::XLEN-1:0]       imem_addr,
    output logic                           retire_valid,
    output logic [cpu_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [cpu_pkg::XLEN-1:0]       retire_value
);
    import cpu_pkg::*;

    // Fetch to decode
    logic [XLEN-1:0]       if_pc, if_instr;
    logic                  stall;

    // Register bank read side
    logic [REG_ADDR_W-1:0] rs1_addr, rs2_addr;
    logic [XLEN-1:0]       rs1_value, rs2_value;

    // Decode to execute
    logic [XLEN-1:0]       de_pc, de_rs1_value, de_rs2_value, de_imm;
    alu_op_t               de_alu_op;
    logic                  de_alu_src, de_branch, de_branch_ne;
    logic                  de_mem_read, de_mem_write, de_reg_write;
    logic [REG_ADDR_W-1:0] de_rd;

    // Execute to memory, plus the redirect
    logic                  branch_taken;
    logic [XLEN-1:0]       branch_target;
    logic [XLEN-1:0]       ex_result, ex_store_data;
    logic                  ex_mem_read, ex_mem_write, ex_reg_write;
    logic [REG_ADDR_W-1:0] ex_rd;

    fetch u_fetch (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
        .imem_data(imem_data), .imem_addr(imem_addr),
        .if_pc(if_pc), .if_instr(if_instr)
    );

    decode u_decode (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .if_pc(if_pc), .if_instr(if_instr),
        .rs1_value(rs1_value), .rs2_value(rs2_value),
        .branch_taken(branch_taken), .ex_reg_write(ex_reg_write), .ex_rd(ex_rd),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .stall(stall),
        .de_pc(de_pc), .de_rs1_value(de_rs1_value), .de_rs2_value(de_rs2_value),
        .de_imm(de_imm), .de_alu_op(de_alu_op), .de_alu_src(de_alu_src),
        .de_branch(de_branch), .de_branch_ne(de_branch_ne),
        .de_mem_read(de_mem_read), .de_mem_write(de_mem_write),
        .de_reg_write(de_reg_write), .de_rd(de_rd)
    );

    execute u_execute (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .de_pc(de_pc), .de_rs1_value(de_rs1_value), .de_rs2_value(de_rs2_value),
        .de_imm(de_imm), .de_alu_op(de_alu_op), .de_alu_src(de_alu_src),
        .de_branch(de_branch), .de_branch_ne(de_branch_ne),
        .de_mem_read(de_mem_read), .de_mem_write(de_mem_write),
        .de_reg_write(de_reg_write), .de_rd(de_rd),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_rd(ex_rd)
    );

    // Writeback strobe is also the retire port
    memory_stage #(
        .RAM_WORDS(RAM_WORDS)
    ) u_memory_stage (
        .clock(clock), .rst_n(rst_n), .enable(enable),
        .ex_result(ex_result), .ex_store_data(ex_store_data),
        .ex_mem_read(ex_mem_read), .ex_mem_write(ex_mem_write),
        .ex_reg_write(ex_reg_write), .ex_rd(ex_rd),
        .mem_reg_write(), .mem_rd(), // Write-through makes these unneeded for hazards
        .wb_write_enable(retire_valid), .wb_rd(retire_rd), .wb_value(retire_value)
    );

    register_bank u_register_bank (
        .clock(clock), .rst_n(rst_n),
        .write_enable(retire_valid), .write_addr(retire_rd), .write_value(retire_value),
        .read_addr1(rs1_addr), .read_addr2(rs2_addr),
        .value1(rs1_value), .value2(rs2_value)
    );

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module memory_stage #(
    parameter int RAM_WORDS = 64
) (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [cpu_pkg::XLEN-1:0]       ex_result,
    input  logic [cpu_pkg::XLEN-1:0]       ex_store_data,
    input  logic                           ex_mem_read,
    input  logic                           ex_mem_write,
    input  logic                           ex_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic                           mem_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0] mem_rd,
    output logic                           wb_write_enable,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_rd,
    output logic [cpu_pkg::XLEN-1:0]       wb_value
);
    import cpu_pkg::*;

    logic [XLEN-1:0] load_data;

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) u_data_ram (
        .clock       (clock),
        .write_enable(ex_mem_write && enable), // Frozen core leaves RAM alone
        .address     (ex_result),
        .write_data  (ex_store_data),
        .read_data   (load_data)
    );

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            mem_reg_write <= 1'b0;
            mem_rd        <= '0;
        end else if (enable) begin
            mem_reg_write <= ex_reg_write;
            mem_rd        <= ex_rd;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            wb_value <= ex_mem_read ? load_data : ex_result;
        end
    end

    // Writeback select, one strobe per enabled cycle
    assign wb_write_enable = mem_reg_write && (mem_rd != '0) && enable;
    assign wb_rd           = mem_rd;

endmodule

`default_nettype wire

/* execute.sv */
`timescale 1ns/10ps
`default_nettype none

module execute (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [cpu_pkg::XLEN-1:0]       de_pc,
    input  logic [cpu_pkg::XLEN-1:0]       de_rs1_value,
    input  logic [cpu_pkg::XLEN-1:0]       de_rs2_value,
    input  logic [cpu_pkg::XLEN-1:0]       de_imm,
    input  cpu_pkg::alu_op_t               de_alu_op,
    input  logic                           de_alu_src,
    input  logic                           de_branch,
    input  logic                           de_branch_ne,
    input  logic                           de_mem_read,
    input  logic                           de_mem_write,
    input  logic                           de_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] de_rd,
    output logic                           branch_taken,
    output logic [cpu_pkg::XLEN-1:0]       branch_target,
    output logic [cpu_pkg::XLEN-1:0]       ex_result,
    output logic [cpu_pkg::XLEN-1:0]       ex_store_data,
    output logic                           ex_mem_read,
    output logic                           ex_mem_write,
    output logic                           ex_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd
);
    import cpu_pkg::*;

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;

    assign operand_b = de_alu_src ? de_imm : de_rs2_value;

    always_comb begin
        case (de_alu_op)
            ALU_ADD: alu_result = de_rs1_value + operand_b;
            ALU_SUB: alu_result = de_rs1_value - operand_b;
            ALU_AND: alu_result = de_rs1_value & operand_b;
            ALU_OR:  alu_result = de_rs1_value | operand_b;
            ALU_XOR: alu_result = de_rs1_value ^ operand_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(de_rs1_value) < $signed(operand_b)};
            default: alu_result = '0;
        endcase
    end

    // Resolved straight from ID/EX, a one-cycle pulse per branch
    assign branch_taken  = de_branch && ((de_rs1_value == de_rs2_value) ^ de_branch_ne);
    assign branch_target = de_pc + de_imm;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_rd        <= '0;
        end else if (enable) begin
            ex_mem_read  <= de_mem_read;
            ex_mem_write <= de_mem_write;
            ex_reg_write <= de_reg_write;
            ex_rd        <= de_rd;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            ex_result     <= alu_result; // Also the load/store address
            ex_store_data <= de_rs2_value;
        end
    end

endmodule

`default_nettype wire

/* decode.sv */
`timescale 1ns/10ps
`default_nettype none

module decode (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           enable,
    input  logic [cpu_pkg::XLEN-1:0]       if_pc,
    input  logic [cpu_pkg::XLEN-1:0]       if_instr,
    input  logic [cpu_pkg::XLEN-1:0]       rs1_value,
    input  logic [cpu_pkg::XLEN-1:0]       rs2_value,
    input  logic                           branch_taken,
    input  logic                           ex_reg_write,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_rd,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                           stall,
    output logic [cpu_pkg::XLEN-1:0]       de_pc,
    output logic [cpu_pkg::XLEN-1:0]       de_rs1_value,
    output logic [cpu_pkg::XLEN-1:0]       de_rs2_value,
    output logic [cpu_pkg::XLEN-1:0]       de_imm,
    output cpu_pkg::alu_op_t               de_alu_op,
    output logic                           de_alu_src,
    output logic                           de_branch,
    output logic                           de_branch_ne,
    output logic                           de_mem_read,
    output logic                           de_mem_write,
    output logic                           de_reg_write,
    output logic [cpu_pkg::REG_ADDR_W-1:0] de_rd
);
    import cpu_pkg::*;

    logic [XLEN-1:0]       instr;
    logic [OPCODE_W-1:0]   opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic [REG_ADDR_W-1:0] rd_field;
    logic [XLEN-1:0]       imm_i, imm_s, imm_b;
    logic                  src1_busy, src2_busy;

    alu_op_t         alu_op;
    logic [XLEN-1:0] imm;
    logic            alu_src, branch, branch_ne, mem_read, mem_write, reg_write;

    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    // Source still owned by an instruction in ID/EX or EX/MEM
    assign src1_busy = (rs1_addr != '0) &&
                       ((de_reg_write && rs1_addr == de_rd) || (ex_reg_write && rs1_addr == ex_rd));
    assign src2_busy = (rs2_addr != '0) &&
                       ((de_reg_write && rs2_addr == de_rd) || (ex_reg_write && rs2_addr == ex_rd));
    assign stall     = src1_busy || src2_busy;

    // A bubble is simply the NOP word run through the decoder
    assign instr    = (stall || branch_taken) ? NOP_INSTR : if_instr;
    assign opcode   = instr[6:0];
    assign rd_field = instr[11:7];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        alu_op    = ALU_ADD;
        imm       = imm_i;
        alu_src   = 1'b0;
        branch    = 1'b0;
        branch_ne = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            OP_REG: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
                    default:           reg_write = 1'b0; // Unsupported R-type
                endcase
            end
            OP_IMM: begin
                alu_src   = 1'b1;
                reg_write = (funct3 == F3_ADD); // ADDI only
            end
            OP_LOAD: begin
                alu_src   = 1'b1;
                mem_read  = (funct3 == F3_WORD);
                reg_write = (funct3 == F3_WORD);
            end
            OP_STORE: begin
                alu_src   = 1'b1;
                imm       = imm_s;
                mem_write = (funct3 == F3_WORD);
            end
            OP_BRANCH: begin
                imm       = imm_b;
                branch    = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
                branch_ne = (funct3 == F3_BNE);
            end
            default: ; // No-op
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            de_branch    <= 1'b0;
            de_branch_ne <= 1'b0;
            de_mem_read  <= 1'b0;
            de_mem_write <= 1'b0;
            de_reg_write <= 1'b0;
            de_rd        <= '0;
        end else if (enable) begin
            de_branch    <= branch;
            de_branch_ne <= branch_ne;
            de_mem_read  <= mem_read;
            de_mem_write <= mem_write;
            de_reg_write <= reg_write && (rd_field != '0); // x0 writes dropped here
            de_rd        <= (reg_write && rd_field != '0) ? rd_field : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            de_pc        <= if_pc;
            de_rs1_value <= rs1_value;
            de_rs2_value <= rs2_value;
            de_imm       <= imm;
            de_alu_op    <= alu_op;
            de_alu_src   <= alu_src;
        end
    end

    a_bubble_no_write: assert property (@(posedge clock) disable iff (!rst_n)
        enable && (stall || branch_taken) |=> !de_reg_write);

endmodule

`default_nettype wire

/* fetch.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch (
    input  logic                     clock,
    input  logic                     rst_n,
    input  logic                     enable,
    input  logic                     stall,
    input  logic                     branch_taken,
    input  logic [cpu_pkg::XLEN-1:0] branch_target,
    input  logic [cpu_pkg::XLEN-1:0] imem_data,
    output logic [cpu_pkg::XLEN-1:0] imem_addr,
    output logic [cpu_pkg::XLEN-1:0] if_pc,
    output logic [cpu_pkg::XLEN-1:0] if_instr
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc;

    assign imem_addr = pc; // Port answers in the same cycle

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc       <= RESET_PC;
            if_instr <= NOP_INSTR;
        end else if (enable) begin
            if (branch_taken) begin // Wins over a stall
                pc       <= branch_target;
                if_instr <= NOP_INSTR; // Kill the word fetched this cycle
            end else if (!stall) begin
                pc       <= pc + 4;
                if_instr <= imem_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable && !branch_taken && !stall) begin
            if_pc <= pc;
        end
    end

    // Branch targets from execute must keep word alignment
    a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n)
        pc[1:0] == 2'b00);

endmodule

`default_nettype wire

/* data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic                     clock,
    input  logic                     write_enable,
    input  logic [cpu_pkg::XLEN-1:0] address,
    input  logic [cpu_pkg::XLEN-1:0] write_data,
    output logic [cpu_pkg::XLEN-1:0] read_data
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(RAM_WORDS);

    logic [XLEN-1:0]   mem [RAM_WORDS];
    logic [ADDR_W-1:0] word_index;

    assign word_index = address[ADDR_W+1:2]; // Byte offset dropped

    always_ff @(posedge clock) begin
        if (write_enable) begin
            mem[word_index] <= write_data;
        end
    end

    assign read_data = mem[word_index];

    // Upper address bits come straight from the ALU and must not alias
    a_write_in_range: assert property (@(posedge clock)
        write_enable |-> (address >> 2) < RAM_WORDS);

endmodule

`default_nettype wire

/* register_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module register_bank (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           write_enable,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] write_addr,
    input  logic [cpu_pkg::XLEN-1:0]       write_value,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr1,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] read_addr2,
    output logic [cpu_pkg::XLEN-1:0]       value1,
    output logic [cpu_pkg::XLEN-1:0]       value2
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && write_addr != '0) begin
            regs[write_addr] <= write_value;
        end
    end

    // Write-through covers the writeback slot, so decode never stalls on it
    assign value1 = (read_addr1 == '0) ? '0 :
                    (write_enable && write_addr == read_addr1) ? write_value : regs[read_addr1];
    assign value2 = (read_addr2 == '0) ? '0 :
                    (write_enable && write_addr == read_addr2) ? write_value : regs[read_addr2];

    // Memory stage filters out x0 destinations before they get here
    a_no_x0_write: assert property (@(posedge clock) disable iff (!rst_n)
        write_enable |-> write_addr != '0);

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // ADDI x0,x0,0, used for flushed slots and bubbles
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes
    localparam logic [OPCODE_W-1:0] OP_REG    = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_IMM    = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_LOAD   = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE  = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_BRANCH = 7'b1100011;

    localparam logic [FUNCT3_W-1:0] F3_ADD  = 3'b000; // ADD, SUB, ADDI
    localparam logic [FUNCT3_W-1:0] F3_SLT  = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND  = 3'b111;
    localparam logic [FUNCT3_W-1:0] F3_WORD = 3'b010; // LW and SW
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;

    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000; // Selects SUB

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

endpackage

`default_nettype wire
